/* tex_pkg.sv */
package tex_pkg;

    // Pixels sampled in parallel.
    localparam int num_lanes = 2;

    // Texels per bilinear footprint, ordered UL, UR, LL, LR.
    localparam int num_texels = 4;

    localparam int texel_bits = 32;

    // A fraction f weights the second input by f/256.
    localparam int blend_bits = 8;

    localparam int info_bits = 8;

    // Cycles through one tex_lerp.
    localparam int lerp_latency = 3;

    localparam int format_bits = 3;

    // Raw texel layouts accepted by the sampler.
    typedef enum logic [format_bits-1:0] {
        fmt_argb8888 = 3'd0,
        fmt_rgb565   = 3'd1,
        fmt_argb1555 = 3'd2,
        fmt_argb4444 = 3'd3,
        fmt_l8       = 3'd4   // Luminance in the low byte.
    } tex_format_e;

    // Per-lane blend pair, index 0 is u and index 1 is v.
    typedef logic [num_lanes-1:0][1:0][blend_bits-1:0] blend_vec_t;

    // Per-lane footprint of raw or converted texels.
    typedef logic [num_lanes-1:0][num_texels-1:0][texel_bits-1:0] texel_vec_t;

    // One ARGB8888 word per lane.
    typedef logic [num_lanes-1:0][texel_bits-1:0] lane_vec_t;

endpackage

/* tex_if.sv */
`timescale 1ns/1ps

interface tex_req_if import tex_pkg::*; ();

    logic                 valid;
    tex_format_e          format;
    blend_vec_t           blends;
    texel_vec_t           texels;
    logic [info_bits-1:0] info;
    logic                 ready;

    modport sampler_side (
        input  valid, format, blends, texels, info,
        output ready
    );

    modport source_side (
        output valid, format, blends, texels, info,
        input  ready
    );

endinterface

interface tex_rsp_if import tex_pkg::*; ();

    logic                 valid;
    lane_vec_t            data;
    logic [info_bits-1:0] info;
    logic                 ready;   // From the consumer.

    modport sampler_side (
        output valid, data, info,
        input  ready
    );

    modport sink_side (
        input  valid, data, info,
        output ready
    );

endinterface

/* tex_format.sv */
`timescale 1ns/1ps

module tex_format import tex_pkg::*; (
    input  tex_format_e           format,
    input  logic [texel_bits-1:0] texel_in,
    output logic [texel_bits-1:0] texel_out
);

    // Widened channels, top bits repeated below.
    logic [7:0] r565;
    logic [7:0] g565;
    logic [7:0] b5;      // Blue sits in bits 4:0 for both 16-bit RGB formats.
    logic [7:0] a1555;
    logic [7:0] r1555;
    logic [7:0] g1555;
    logic [7:0] a4444;
    logic [7:0] r4444;
    logic [7:0] g4444;
    logic [7:0] b4444;
    logic [7:0] lum;

    assign r565 = {texel_in[15:11], texel_in[15:13]};
    assign g565 = {texel_in[10:5], texel_in[10:9]};
    assign b5   = {texel_in[4:0], texel_in[4:2]};

    assign a1555 = {8{texel_in[15]}};   // 0x00 or 0xFF.
    assign r1555 = {texel_in[14:10], texel_in[14:12]};
    assign g1555 = {texel_in[9:5], texel_in[9:7]};

    assign a4444 = {2{texel_in[15:12]}};
    assign r4444 = {2{texel_in[11:8]}};
    assign g4444 = {2{texel_in[7:4]}};
    assign b4444 = {2{texel_in[3:0]}};

    assign lum = texel_in[7:0];

    always_comb begin
        case (format)
            fmt_argb8888: begin
                texel_out = texel_in;
            end
            fmt_rgb565: begin
                texel_out = {8'hff, r565, g565, b5};
            end
            fmt_argb1555: begin
                texel_out = {a1555, r1555, g1555, b5};
            end
            fmt_argb4444: begin
                texel_out = {a4444, r4444, g4444, b4444};
            end
            fmt_l8: begin
                texel_out = {8'hff, lum, lum, lum};
            end
            default: begin
                texel_out = '0;   // Unknown codes give black, alpha zero.
            end
        endcase
    end

endmodule

/* tex_lerp.sv */
`timescale 1ns/1ps

module tex_lerp import tex_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [7:0]            in1,
    input  logic [7:0]            in2,
    input  logic [blend_bits-1:0] frac,
    output logic [7:0]            out
);

    // Weight of in1 is 256 - frac, so the two weights always sum to 256.
    logic [blend_bits:0]     weight1;
    logic [blend_bits+7:0]   prod1;
    logic [blend_bits+7:0]   prod2;
    logic [blend_bits+7:0]   sum;

    assign weight1 = {1'b1, {blend_bits{1'b0}}} - {1'b0, frac};

    // Datapath only, so rst_n has nothing to clear here.
    always_ff @(posedge clk) begin
        if (enable) begin
            prod1 <= in1 * weight1;   // Stage 1.
            prod2 <= in2 * frac;
            sum   <= prod1 + prod2;   // Stage 2.
            out   <= sum[blend_bits +: 8];   // Stage 3, divide by 256.
        end
    end

endmodule

/* tex_sampler.sv */
`timescale 1ns/1ps

module tex_sampler import tex_pkg::*; (
    input logic             clk,
    input logic             rst_n,
    tex_req_if.sampler_side req,
    tex_rsp_if.sampler_side rsp
);

    logic stall;

    texel_vec_t fmt_texels;

    // Stage 0.
    logic                 valid_s0;
    logic [info_bits-1:0] info_s0;
    blend_vec_t           blends_s0;
    texel_vec_t           texels_s0;

    logic [num_lanes-1:0][blend_bits-1:0] v_s0;

    // Alongside the horizontal row.
    logic [lerp_latency-1:0]                                 valid_d1;
    logic [lerp_latency-1:0][info_bits-1:0]                  info_d1;
    logic [lerp_latency-1:0][num_lanes-1:0][blend_bits-1:0] v_d1;

    // Alongside the vertical row.
    logic [lerp_latency-1:0]                valid_d2;
    logic [lerp_latency-1:0][info_bits-1:0] info_d2;

    lane_vec_t row_up;
    lane_vec_t row_lo;

    for (genvar i = 0; i < num_lanes; i++) begin : g_fmt_lane
        for (genvar t = 0; t < num_texels; t++) begin : g_fmt_texel
            tex_format u_format (
                .format    (req.format),
                .texel_in  (req.texels[i][t]),
                .texel_out (fmt_texels[i][t])
            );
        end
    end

    // Valid bits are the only state that reset must clear.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_s0 <= 1'b0;
            valid_d1 <= '0;
            valid_d2 <= '0;
        end else if (!stall) begin
            valid_s0 <= req.valid;
            valid_d1 <= {valid_d1[lerp_latency-2:0], valid_s0};
            valid_d2 <= {valid_d2[lerp_latency-2:0], valid_d1[lerp_latency-1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            texels_s0 <= fmt_texels;
            blends_s0 <= req.blends;
            info_s0   <= req.info;
            info_d1   <= {info_d1[lerp_latency-2:0], info_s0};
            v_d1      <= {v_d1[lerp_latency-2:0], v_s0};
            info_d2   <= {info_d2[lerp_latency-2:0], info_d1[lerp_latency-1]};
        end
    end

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assign v_s0[i] = blends_s0[i][1];

        for (genvar c = 0; c < 4; c++) begin : g_chan
            // UL with UR by u.
            tex_lerp u_lerp_up (
                .clk    (clk),
                .rst_n  (rst_n),
                .enable (!stall),
                .in1    (texels_s0[i][0][c*8 +: 8]),
                .in2    (texels_s0[i][1][c*8 +: 8]),
                .frac   (blends_s0[i][0]),
                .out    (row_up[i][c*8 +: 8])
            );

            // LL with LR by u.
            tex_lerp u_lerp_lo (
                .clk    (clk),
                .rst_n  (rst_n),
                .enable (!stall),
                .in1    (texels_s0[i][2][c*8 +: 8]),
                .in2    (texels_s0[i][3][c*8 +: 8]),
                .frac   (blends_s0[i][0]),
                .out    (row_lo[i][c*8 +: 8])
            );

            // Upper row with lower row by the delayed v.
            tex_lerp u_lerp_v (
                .clk    (clk),
                .rst_n  (rst_n),
                .enable (!stall),
                .in1    (row_up[i][c*8 +: 8]),
                .in2    (row_lo[i][c*8 +: 8]),
                .frac   (v_d1[lerp_latency-1][i]),
                .out    (rsp.data[i][c*8 +: 8])
            );
        end
    end

    assign rsp.valid = valid_d2[lerp_latency-1];
    assign rsp.info  = info_d2[lerp_latency-1];

    // A held response freezes the whole chain.
    assign stall     = rsp.valid && !rsp.ready;
    assign req.ready = !stall;

endmodule

/* tex_sampler_top.sv */
`timescale 1ns/1ps

module tex_sampler_top import tex_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 req_valid,
    input  tex_format_e          req_format,
    input  blend_vec_t           req_blends,
    input  texel_vec_t           req_texels,
    input  logic [info_bits-1:0] req_info,
    output logic                 req_ready,

    output logic                 rsp_valid,
    output lane_vec_t            rsp_data,
    output logic [info_bits-1:0] rsp_info,
    input  logic                 rsp_ready
);

    tex_req_if req_bus ();
    tex_rsp_if rsp_bus ();

    // Request side, the top acts as source.
    assign req_bus.valid  = req_valid;
    assign req_bus.format = req_format;
    assign req_bus.blends = req_blends;
    assign req_bus.texels = req_texels;
    assign req_bus.info   = req_info;
    assign req_ready      = req_bus.ready;

    // Response side, the top acts as sink.
    assign rsp_valid     = rsp_bus.valid;
    assign rsp_data      = rsp_bus.data;
    assign rsp_info      = rsp_bus.info;
    assign rsp_bus.ready = rsp_ready;

    tex_sampler u_sampler (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_bus.sampler_side),
        .rsp   (rsp_bus.sampler_side)
    );

endmodule

/* tex_sampler_checker.sv */
`timescale 1ns/1ps

module tex_sampler_checker import tex_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 req_ready,
    input logic                 rsp_valid,
    input lane_vec_t            rsp_data,
    input logic [info_bits-1:0] rsp_info,
    input logic                 rsp_ready
);

    logic stall;

    assign stall = rsp_valid && !rsp_ready;   // Response held by the consumer.

    reset_clears_valid: assert property (@(posedge clk) $rose(rst_n) |-> !rsp_valid)
        else $error("rsp_valid high in the first cycle after reset");

    ready_tracks_stall: assert property (@(posedge clk) disable iff (!rst_n) req_ready == !stall)
        else $error("req_ready differs from the inverse of stall");

    // Held response stays put into the next cycle.
    held_response_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable(rsp_valid) && $stable(rsp_data) && $stable(rsp_info)
    ) else $error("response changed while held");

endmodule

bind tex_sampler_top tex_sampler_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .rsp_info  (rsp_info),
    .rsp_ready (rsp_ready)
);

/* tex_sampler_tb.sv */
`timescale 1ns/1ps

module tex_sampler_tb import tex_pkg::*; ();

    localparam int num_entries    = 24;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = num_entries * 4 + 7 + reset_cycles + 100;
    localparam int rsp_latency    = 7;

    typedef struct {
        tex_format_e          fmt;
        texel_vec_t           texels;
        blend_vec_t           blends;
        logic [info_bits-1:0] info;
        logic                 stall;      // Back-pressure while in flight.
        lane_vec_t            expected;
    } entry_t;

    typedef struct {
        int index;
        int accept_cycle;
    } pending_t;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    tex_format_e          req_format;
    blend_vec_t           req_blends;
    texel_vec_t           req_texels;
    logic [info_bits-1:0] req_info;
    logic                 req_ready;
    logic                 rsp_valid;
    lane_vec_t            rsp_data;
    logic [info_bits-1:0] rsp_info;
    logic                 rsp_ready;

    entry_t   tbl [num_entries];
    pending_t pend_q [$];
    integer   seed;
    int       n_built = 0;
    int       cycle = 0;
    int       resp_count = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;
    int       errors = 0;
    int       hold_cnt = 0;
    logic     bp_on = 1'b0;

    // Expected valid per pipeline stage with the MSB at the response port.
    logic [rsp_latency-1:0] exp_valid = '0;
    logic                   exp_held;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    tex_sampler_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_format (req_format),
        .req_blends (req_blends),
        .req_texels (req_texels),
        .req_info   (req_info),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_info   (rsp_info),
        .rsp_ready  (rsp_ready)
    );

    // Repeat an n-bit field from its top bit down until 8 bits are filled.
    function automatic logic [7:0] widen(input logic [7:0] field, input int n);
        logic [7:0] w;
        for (int b = 0; b < 8; b++) begin
            w[7-b] = field[n-1-(b % n)];
        end
        return w;
    endfunction

    function automatic logic [31:0] expand_texel(input tex_format_e fmt, input logic [31:0] t);
        logic [31:0] argb;
        case (fmt)
            fmt_argb8888: argb = t;
            fmt_rgb565:   argb = {8'hff, widen(t[15:11], 5), widen(t[10:5], 6), widen(t[4:0], 5)};
            fmt_argb1555: argb = {widen(t[15], 1), widen(t[14:10], 5), widen(t[9:5], 5),
                                  widen(t[4:0], 5)};
            fmt_argb4444: argb = {widen(t[15:12], 4), widen(t[11:8], 4), widen(t[7:4], 4),
                                  widen(t[3:0], 4)};
            fmt_l8:       argb = {8'hff, t[7:0], t[7:0], t[7:0]};
            default:      argb = 32'h0;
        endcase
        return argb;
    endfunction

    // Weights 256 - f and f with the result truncated to the top byte.
    function automatic logic [7:0] lerp8(input logic [7:0] a, input logic [7:0] b,
                                         input logic [7:0] f);
        int mix;
        mix = int'(a) * (256 - int'(f)) + int'(b) * int'(f);
        return mix[15:8];
    endfunction

    function automatic logic [31:0] bilinear(input tex_format_e fmt, input logic [3:0][31:0] tx,
                                             input logic [7:0] u, input logic [7:0] v);
        logic [31:0] ul, ur, ll, lr, res;
        logic [7:0]  up, lo;
        ul = expand_texel(fmt, tx[0]);
        ur = expand_texel(fmt, tx[1]);
        ll = expand_texel(fmt, tx[2]);
        lr = expand_texel(fmt, tx[3]);
        for (int c = 0; c < 4; c++) begin
            up = lerp8(ul[c*8 +: 8], ur[c*8 +: 8], u);
            lo = lerp8(ll[c*8 +: 8], lr[c*8 +: 8], u);
            res[c*8 +: 8] = lerp8(up, lo, v);
        end
        return res;
    endfunction

    task automatic random_texels(output texel_vec_t tx);
        for (int i = 0; i < num_lanes; i++) begin
            for (int t = 0; t < num_texels; t++) begin
                tx[i][t] = $random(seed);
            end
        end
    endtask

    task automatic add_entry(input tex_format_e fmt, input texel_vec_t tx, input blend_vec_t bl,
                             input logic [info_bits-1:0] info, input logic stall);
        tbl[n_built].fmt    = fmt;
        tbl[n_built].texels = tx;
        tbl[n_built].blends = bl;
        tbl[n_built].info   = info;
        tbl[n_built].stall  = stall;
        for (int i = 0; i < num_lanes; i++) begin
            tbl[n_built].expected[i] = bilinear(fmt, tx[i], bl[i][0], bl[i][1]);
        end
        n_built++;
    endtask

    task automatic build_table();
        texel_vec_t tx;
        blend_vec_t bl;
        integer     rnd;
        logic [2:0] fmt_code;
        logic [7:0] u_vals [6];
        logic [7:0] v_vals [6];
        u_vals = '{8'd0, 8'd128, 8'd255, 8'd64, 8'd255, 8'd128};
        v_vals = '{8'd128, 8'd0, 8'd255, 8'd192, 8'd1, 8'd37};
        // Zero blends return the converted UL texel. Code 5 is unused.
        for (int f = 0; f < 6; f++) begin
            random_texels(tx);
            add_entry(tex_format_e'(3'(f)), tx, '0, info_bits'(8'h10 + f), 1'b0);
        end
        for (int k = 0; k < 6; k++) begin
            random_texels(tx);
            bl[0][0] = u_vals[k];
            bl[0][1] = v_vals[k];
            bl[1][0] = v_vals[k];   // Lane 1 swaps u and v.
            bl[1][1] = u_vals[k];
            add_entry((k % 2 == 0) ? fmt_argb8888 : fmt_rgb565, tx, bl,
                      info_bits'(8'h20 + k), 1'b0);
        end
        for (int k = 0; k < num_entries - 12; k++) begin
            random_texels(tx);
            rnd = $random(seed);
            bl = rnd;
            rnd = $random(seed);
            fmt_code = 3'($unsigned(rnd) % 5);
            rnd = $random(seed);
            add_entry(tex_format_e'(fmt_code), tx, bl, rnd[info_bits-1:0], 1'b1);
        end
    endtask

    task automatic drive_request(input int i);
        req_valid  = 1'b1;
        req_format = tbl[i].fmt;
        req_texels = tbl[i].texels;
        req_blends = tbl[i].blends;
        req_info   = tbl[i].info;
    endtask

    task automatic check_reset_state();
        logic ok;
        ok = 1'b1;
        if (rsp_valid !== 1'b0) begin
            $display("CHECK FAILED rsp_valid: got 0x%h expected 0x0", rsp_valid);
            ok = 1'b0;
        end
        if (req_ready !== 1'b1) begin
            $display("CHECK FAILED req_ready: got 0x%h expected 0x1", req_ready);
            ok = 1'b0;
        end
        if (ok) begin
            tests_passed++;
            $display("test reset: ok");
        end else begin
            tests_failed++;
            $display("test reset: FAILED");
        end
    endtask

    task automatic check_response();
        pending_t p;
        logic     ok;
        int       latency;
        if (pend_q.size() == 0) begin
            $display("Response with info 0x%h arrived with no request outstanding", rsp_info);
            errors++;
        end else begin
            p  = pend_q.pop_front();
            ok = 1'b1;
            for (int i = 0; i < num_lanes; i++) begin
                if (rsp_data[i] !== tbl[p.index].expected[i]) begin
                    $display("CHECK FAILED rsp_data[%0d]: got 0x%h expected 0x%h", i,
                             rsp_data[i], tbl[p.index].expected[i]);
                    ok = 1'b0;
                end
            end
            if (rsp_info !== tbl[p.index].info) begin
                $display("CHECK FAILED rsp_info: got 0x%h expected 0x%h", rsp_info,
                         tbl[p.index].info);
                ok = 1'b0;
            end
            latency = cycle - p.accept_cycle;
            if (!tbl[p.index].stall && latency != 7) begin
                $display("Response arrived %0d cycles after its request instead of 7", latency);
                ok = 1'b0;
            end
            resp_count++;
            if (ok) begin
                tests_passed++;
                $display("test %0d format %0d info 0x%h: ok", p.index, tbl[p.index].fmt,
                         tbl[p.index].info);
            end else begin
                tests_failed++;
                $display("test %0d format %0d info 0x%h: FAILED", p.index, tbl[p.index].fmt,
                         tbl[p.index].info);
            end
        end
    endtask

    task automatic finish_run();
        $display("Tests passed %0d, failed %0d, other errors %0d", tests_passed, tests_failed,
                 errors);
        if (tests_failed == 0 && errors == 0 && pend_q.size() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin
        pending_t p;
        seed       = 32'h933e;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_format = fmt_argb8888;
        req_texels = '0;
        req_blends = '0;
        req_info   = '0;
        build_table();
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_reset_state();
        for (int i = 0; i < num_entries; i++) begin
            @(negedge clk);
            if (tbl[i].stall && !bp_on) begin
                req_valid = 1'b0;
                while (pend_q.size() != 0) @(negedge clk);   // Drain the streaming phase.
                bp_on = 1'b1;
            end
            drive_request(i);
            @(posedge clk);
            while (!req_ready) @(posedge clk);
            p.index        = i;
            p.accept_cycle = cycle;
            pend_q.push_back(p);
        end
        @(negedge clk);
        req_valid = 1'b0;
        while (resp_count < num_entries) @(negedge clk);
        repeat (10) @(negedge clk);   // Catches a duplicated response.
        finish_run();
    end

    // Random hold spans of one to four cycles.
    initial begin
        integer pick;
        rsp_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (hold_cnt != 0) begin
                hold_cnt--;
            end else if (bp_on) begin
                pick = $random(seed);
                if (pick[1]) begin
                    hold_cnt = 1 + pick[3:2];
                end
            end
            @(negedge clk);
            rsp_ready = (hold_cnt == 0);
        end
    end

    // Fixed-latency chain that freezes while its output is held.
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_valid = '0;
        end else begin
            exp_held = exp_valid[rsp_latency-1] && !rsp_ready;
            if (rsp_valid !== exp_valid[rsp_latency-1]) begin
                $display("CHECK FAILED rsp_valid: got 0x%h expected 0x%h", rsp_valid,
                         exp_valid[rsp_latency-1]);
                errors++;
            end
            if (req_ready !== !exp_held) begin
                $display("CHECK FAILED req_ready: got 0x%h expected 0x%h", req_ready,
                         !exp_held);
                errors++;
            end
            if (rsp_valid && rsp_ready) begin
                check_response();
            end
            if (!exp_held) begin
                exp_valid = {exp_valid[rsp_latency-2:0], req_valid};
            end
        end
    end

    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("Timeout after %0d cycles, %0d of %0d responses received", cycle,
                     resp_count, num_entries);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

/* tex_sampler.f */
tex_pkg.sv
tex_if.sv
tex_format.sv
tex_lerp.sv
tex_sampler.sv
tex_sampler_top.sv
tex_sampler_checker.sv
tex_sampler_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tex_sampler_tb -Mdir obj_dir -f tex_sampler.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtex_sampler_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$log"; then
    exit 1
fi
exit 0
